//--- rtl/cpu_pkg.sv
package cpu_pkg;

    localparam int ADDR_W    = 6;
    localparam int DATA_W    = 16;
    localparam int REG_COUNT = 8;
    localparam int REG_SEL_W = $clog2(REG_COUNT);

    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [DATA_W-1:0]    word_t;
    typedef logic [DATA_W-1:0]    instr_t;
    typedef logic [REG_SEL_W-1:0] reg_sel_t;

    // instruction word is opcode, x, y, z from the top down
    localparam int FIELD_W = 4;
    localparam int OPC_LSB = 12;
    localparam int X_LSB   = 8;
    localparam int Y_LSB   = 4;
    localparam int Z_LSB   = 0;
    // indirect flag inside one operand field
    localparam int IND_BIT = 3;

    typedef enum logic [3:0] {
        OP_MOV  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_MUL  = 4'd3,
        OP_IN   = 4'd7,
        OP_OUT  = 4'd8,
        OP_STOP = 4'd15
    } opcode_e;

    typedef enum logic [1:0] {ALU_PASS, ALU_ADD, ALU_SUB, ALU_MUL} alu_op_e;

    typedef enum logic [2:0] {
        PH_BOOT,
        PH_FETCH,
        PH_OPERAND,
        PH_EXEC,
        PH_HALT
    } phase_e;

    typedef enum logic [1:0] {SLOT_X, SLOT_Y, SLOT_Z} slot_e;

    typedef enum logic [1:0] {ST_ISSUE, ST_WAIT, ST_CAPTURE, ST_USE} mem_step_e;

    // MAR sources and write-back sources
    typedef enum logic [1:0] {MAR_PC, MAR_REG, MAR_MDR, MAR_DEST} mar_src_e;
    typedef enum logic [1:0] {A_ALU, A_Y, A_IN} a_src_e;

endpackage

//--- rtl/cpu_ctrl_if.sv
interface cpu_ctrl_if;

    // register load controls from the sequencer
    cpu_pkg::mar_src_e mar_src;
    logic              mar_ld;
    logic              mdr_ld;
    logic              ir_ld;
    logic              pc_ld_start;
    logic              pc_inc;
    logic              opnd_ld;
    cpu_pkg::slot_e    slot;
    logic              dest_ld;
    logic              a_ld;
    cpu_pkg::a_src_e   a_src;
    logic              r_ld;
    logic              mem_we;

    // decoded instruction fields from the datapath
    cpu_pkg::opcode_e  opcode;
    // bit 0 is x and bit 2 is z
    logic [2:0]        ind_bits;

    modport seq (
        output mar_src, mar_ld, mdr_ld, ir_ld, pc_ld_start, pc_inc,
        output opnd_ld, slot, dest_ld, a_ld, a_src, r_ld, mem_we,
        input  opcode, ind_bits
    );

    modport dp (
        input  mar_src, mar_ld, mdr_ld, ir_ld, pc_ld_start, pc_inc,
        input  opnd_ld, slot, dest_ld, a_ld, a_src, r_ld, mem_we,
        output opcode, ind_bits
    );

endinterface

//--- rtl/cpu_step_counter.sv
module cpu_step_counter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  step_clear,
    input  logic                  step_adv,
    input  logic                  slot_adv,
    output cpu_pkg::mem_step_e    step,
    output cpu_pkg::slot_e        slot
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step <= cpu_pkg::ST_ISSUE;
            slot <= cpu_pkg::SLOT_X;
        end else if (step_clear) begin
            step <= cpu_pkg::ST_ISSUE;
            slot <= cpu_pkg::SLOT_X;
        end else begin
            if (step_adv) begin
                if (step == cpu_pkg::ST_USE) begin
                    step <= cpu_pkg::ST_ISSUE;
                end else begin
                    step <= cpu_pkg::mem_step_e'(step + 2'd1);
                end
            end
            // x, y, z then back to x
            if (slot_adv) begin
                if (slot == cpu_pkg::SLOT_Z) begin
                    slot <= cpu_pkg::SLOT_X;
                end else begin
                    slot <= cpu_pkg::slot_e'(slot + 2'd1);
                end
            end
        end
    end

endmodule

//--- rtl/cpu_sequencer.sv
module cpu_sequencer (
    input  logic                  clk,
    input  logic                  rst_n,
    cpu_ctrl_if.seq               ctrl,
    input  cpu_pkg::mem_step_e    step,
    input  cpu_pkg::slot_e        slot,
    output logic                  step_clear,
    output logic                  step_adv,
    output logic                  slot_adv,
    output cpu_pkg::alu_op_e      alu_op,
    output logic                  status
);

    cpu_pkg::phase_e phase, phase_d;
    // busy means MAR holds the address of a read in flight
    logic            busy, busy_d;
    logic            ind_pass, ind_pass_d;
    logic [2:0]      uses;
    logic            writes;
    logic            slot_used;
    logic            slot_ind;

    // operand usage per opcode with bit 0 for x
    always_comb begin
        uses       = 3'b000;
        writes     = 1'b0;
        alu_op     = cpu_pkg::ALU_PASS;
        ctrl.a_src = cpu_pkg::A_ALU;
        case (ctrl.opcode)
            cpu_pkg::OP_MOV: begin
                uses       = 3'b011;
                writes     = 1'b1;
                ctrl.a_src = cpu_pkg::A_Y;
            end
            cpu_pkg::OP_ADD: begin
                uses   = 3'b111;
                writes = 1'b1;
                alu_op = cpu_pkg::ALU_ADD;
            end
            cpu_pkg::OP_SUB: begin
                uses   = 3'b111;
                writes = 1'b1;
                alu_op = cpu_pkg::ALU_SUB;
            end
            cpu_pkg::OP_MUL: begin
                uses   = 3'b111;
                writes = 1'b1;
                alu_op = cpu_pkg::ALU_MUL;
            end
            cpu_pkg::OP_IN: begin
                uses       = 3'b001;
                writes     = 1'b1;
                ctrl.a_src = cpu_pkg::A_IN;
            end
            cpu_pkg::OP_OUT: begin
                uses = 3'b001;
            end
            default: begin
                uses = 3'b000;
            end
        endcase
    end

    assign slot_used = uses[slot];
    assign slot_ind  = ctrl.ind_bits[slot];
    assign ctrl.slot = slot;
    assign status    = (phase == cpu_pkg::PH_HALT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase    <= cpu_pkg::PH_BOOT;
            busy     <= 1'b0;
            ind_pass <= 1'b0;
        end else begin
            phase    <= phase_d;
            busy     <= busy_d;
            ind_pass <= ind_pass_d;
        end
    end

    always_comb begin
        phase_d          = phase;
        busy_d           = busy;
        ind_pass_d       = ind_pass;
        step_clear       = 1'b0;
        step_adv         = 1'b0;
        slot_adv         = 1'b0;
        ctrl.mar_src     = cpu_pkg::MAR_PC;
        ctrl.mar_ld      = 1'b0;
        ctrl.mdr_ld      = 1'b0;
        ctrl.ir_ld       = 1'b0;
        ctrl.pc_ld_start = 1'b0;
        ctrl.pc_inc      = 1'b0;
        ctrl.opnd_ld     = 1'b0;
        ctrl.dest_ld     = 1'b0;
        ctrl.a_ld        = 1'b0;
        ctrl.r_ld        = 1'b0;
        ctrl.mem_we      = 1'b0;
        case (phase)
            cpu_pkg::PH_BOOT: begin
                ctrl.pc_ld_start = 1'b1;
                phase_d          = cpu_pkg::PH_FETCH;
            end
            cpu_pkg::PH_FETCH: begin
                if (!busy) begin
                    // first cycle loads MAR and the last one hands over
                    if (step == cpu_pkg::ST_ISSUE) begin
                        ctrl.mar_ld = 1'b1;
                        busy_d      = 1'b1;
                    end else begin
                        step_clear = 1'b1;
                        phase_d    = cpu_pkg::PH_OPERAND;
                    end
                end else if (step != cpu_pkg::ST_USE) begin
                    step_adv    = 1'b1;
                    ctrl.mdr_ld = (step == cpu_pkg::ST_CAPTURE);
                end else begin
                    ctrl.ir_ld  = 1'b1;
                    ctrl.pc_inc = 1'b1;
                    busy_d      = 1'b0;
                end
            end
            cpu_pkg::PH_OPERAND: begin
                if (!busy) begin
                    if (step != cpu_pkg::ST_ISSUE) begin
                        step_clear = 1'b1;
                        phase_d    = cpu_pkg::PH_EXEC;
                    end else if (slot_used) begin
                        ctrl.mar_src = cpu_pkg::MAR_REG;
                        ctrl.mar_ld  = 1'b1;
                        busy_d       = 1'b1;
                    end else if (slot == cpu_pkg::SLOT_Z) begin
                        // step leaves ISSUE to mark the phase end
                        step_adv = 1'b1;
                    end else begin
                        slot_adv = 1'b1;
                    end
                end else if (step != cpu_pkg::ST_USE) begin
                    step_adv    = 1'b1;
                    ctrl.mdr_ld = (step == cpu_pkg::ST_CAPTURE);
                end else if (slot_ind && !ind_pass) begin
                    // MDR holds the pointer whose target is read next
                    ctrl.mar_src = cpu_pkg::MAR_MDR;
                    ctrl.mar_ld  = 1'b1;
                    ctrl.dest_ld = (slot == cpu_pkg::SLOT_X);
                    ind_pass_d   = 1'b1;
                    step_adv     = 1'b1;
                end else begin
                    ctrl.opnd_ld = 1'b1;
                    ind_pass_d   = 1'b0;
                    busy_d       = 1'b0;
                    if (!slot_ind) begin
                        ctrl.mar_src = cpu_pkg::MAR_REG;
                        ctrl.dest_ld = (slot == cpu_pkg::SLOT_X);
                    end
                    if (slot != cpu_pkg::SLOT_Z) begin
                        slot_adv = 1'b1;
                        step_adv = 1'b1;
                    end
                end
            end
            cpu_pkg::PH_EXEC: begin
                step_adv = (step != cpu_pkg::ST_USE);
                case (step)
                    cpu_pkg::ST_ISSUE: begin
                        ctrl.a_ld    = writes;
                        ctrl.mar_src = cpu_pkg::MAR_DEST;
                        ctrl.mar_ld  = writes;
                        ctrl.r_ld    = (ctrl.opcode == cpu_pkg::OP_OUT);
                    end
                    cpu_pkg::ST_WAIT: begin
                        ctrl.mem_we = writes;
                    end
                    cpu_pkg::ST_CAPTURE: begin
                        // bubble so the next read sees the new word
                        ctrl.mem_we = 1'b0;
                    end
                    default: begin
                        step_clear = 1'b1;
                        if (ctrl.opcode == cpu_pkg::OP_STOP) begin
                            phase_d = cpu_pkg::PH_HALT;
                        end else begin
                            phase_d = cpu_pkg::PH_FETCH;
                        end
                    end
                endcase
            end
            cpu_pkg::PH_HALT: begin
                phase_d = cpu_pkg::PH_HALT;
            end
            default: begin
                phase_d = cpu_pkg::PH_BOOT;
            end
        endcase
    end

endmodule

//--- rtl/cpu_alu.sv
module cpu_alu (
    input  cpu_pkg::alu_op_e op,
    input  cpu_pkg::word_t   y,
    input  cpu_pkg::word_t   z,
    output cpu_pkg::word_t   f
);

    logic [2*cpu_pkg::DATA_W-1:0] product;

    assign product = y * z;

    always_comb begin
        case (op)
            cpu_pkg::ALU_ADD: f = y + z;
            cpu_pkg::ALU_SUB: f = y - z;
            // low half of the product only
            cpu_pkg::ALU_MUL: f = product[cpu_pkg::DATA_W-1:0];
            default:          f = y;
        endcase
    end

endmodule

//--- rtl/cpu_datapath.sv
module cpu_datapath #(
    parameter cpu_pkg::addr_t PROG_START = 6'd8
) (
    input  logic           clk,
    input  logic           rst_n,
    cpu_ctrl_if.dp         ctrl,
    input  cpu_pkg::word_t mem,
    input  cpu_pkg::word_t in,
    output cpu_pkg::word_t alu_y,
    output cpu_pkg::word_t alu_z,
    input  cpu_pkg::word_t alu_f,
    output cpu_pkg::addr_t addr,
    output cpu_pkg::word_t data,
    output logic           we,
    output cpu_pkg::word_t out,
    output cpu_pkg::addr_t pc
);

    cpu_pkg::addr_t                mar;
    cpu_pkg::addr_t                mar_d;
    cpu_pkg::addr_t                dest_addr;
    cpu_pkg::word_t                mdr;
    cpu_pkg::instr_t               ir;
    cpu_pkg::word_t                x_val;
    cpu_pkg::word_t                y_val;
    cpu_pkg::word_t                z_val;
    cpu_pkg::word_t                a_reg;
    cpu_pkg::word_t                a_d;
    cpu_pkg::reg_sel_t             reg_sel;
    logic [cpu_pkg::FIELD_W-1:0]   fx;
    logic [cpu_pkg::FIELD_W-1:0]   fy;
    logic [cpu_pkg::FIELD_W-1:0]   fz;

    // instruction decode
    assign fx = ir[cpu_pkg::X_LSB +: cpu_pkg::FIELD_W];
    assign fy = ir[cpu_pkg::Y_LSB +: cpu_pkg::FIELD_W];
    assign fz = ir[cpu_pkg::Z_LSB +: cpu_pkg::FIELD_W];
    assign ctrl.opcode   = cpu_pkg::opcode_e'(ir[cpu_pkg::OPC_LSB +: cpu_pkg::FIELD_W]);
    assign ctrl.ind_bits = {fz[cpu_pkg::IND_BIT], fy[cpu_pkg::IND_BIT], fx[cpu_pkg::IND_BIT]};

    // register number of the slot being read
    always_comb begin
        case (ctrl.slot)
            cpu_pkg::SLOT_Y: reg_sel = fy[cpu_pkg::REG_SEL_W-1:0];
            cpu_pkg::SLOT_Z: reg_sel = fz[cpu_pkg::REG_SEL_W-1:0];
            default:         reg_sel = fx[cpu_pkg::REG_SEL_W-1:0];
        endcase
    end

    always_comb begin
        case (ctrl.mar_src)
            cpu_pkg::MAR_REG: mar_d = cpu_pkg::addr_t'(reg_sel);
            cpu_pkg::MAR_MDR: mar_d = mdr[cpu_pkg::ADDR_W-1:0];
            cpu_pkg::MAR_DEST: mar_d = dest_addr;
            default:          mar_d = pc;
        endcase
    end

    always_comb begin
        case (ctrl.a_src)
            cpu_pkg::A_Y:  a_d = y_val;
            cpu_pkg::A_IN: a_d = in;
            default:       a_d = alu_f;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc  <= '0;
            mar <= '0;
            ir  <= '0;
            out <= '0;
        end else begin
            if (ctrl.pc_ld_start) begin
                pc <= PROG_START;
            end else if (ctrl.pc_inc) begin
                pc <= pc + 1'b1;
            end
            if (ctrl.mar_ld) begin
                mar <= mar_d;
            end
            if (ctrl.ir_ld) begin
                ir <= mdr;
            end
            if (ctrl.r_ld) begin
                out <= x_val;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.mdr_ld) begin
            mdr <= mem;
        end
        // x destination follows the MAR source of the same cycle
        if (ctrl.dest_ld) begin
            dest_addr <= mar_d;
        end
        if (ctrl.opnd_ld) begin
            case (ctrl.slot)
                cpu_pkg::SLOT_Y: y_val <= mdr;
                cpu_pkg::SLOT_Z: z_val <= mdr;
                default:         x_val <= mdr;
            endcase
        end
        if (ctrl.a_ld) begin
            a_reg <= a_d;
        end
    end

    assign alu_y = y_val;
    assign alu_z = z_val;
    assign addr  = mar;
    assign we    = ctrl.mem_we;
    assign data  = ctrl.mem_we ? a_reg : '0;

endmodule

//--- rtl/cpu_top.sv
module cpu_top #(
    parameter cpu_pkg::addr_t PROG_START = 6'd8
) (
    input  logic           clk,
    input  logic           rst_n,
    input  cpu_pkg::word_t mem,
    input  cpu_pkg::word_t in,
    output logic           status,
    output logic           we,
    output cpu_pkg::addr_t addr,
    output cpu_pkg::word_t data,
    output cpu_pkg::word_t out,
    output cpu_pkg::addr_t pc
);

    cpu_pkg::mem_step_e step;
    cpu_pkg::slot_e     slot;
    cpu_pkg::alu_op_e   alu_op;
    cpu_pkg::word_t     alu_y;
    cpu_pkg::word_t     alu_z;
    cpu_pkg::word_t     alu_f;
    logic               step_clear;
    logic               step_adv;
    logic               slot_adv;

    cpu_ctrl_if ctrl_bus ();

    cpu_sequencer u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl_bus.seq),
        .step       (step),
        .slot       (slot),
        .step_clear (step_clear),
        .step_adv   (step_adv),
        .slot_adv   (slot_adv),
        .alu_op     (alu_op),
        .status     (status)
    );

    cpu_step_counter u_steps (
        .clk        (clk),
        .rst_n      (rst_n),
        .step_clear (step_clear),
        .step_adv   (step_adv),
        .slot_adv   (slot_adv),
        .step       (step),
        .slot       (slot)
    );

    cpu_datapath #(
        .PROG_START (PROG_START)
    ) u_dp (
        .clk   (clk),
        .rst_n (rst_n),
        .ctrl  (ctrl_bus.dp),
        .mem   (mem),
        .in    (in),
        .alu_y (alu_y),
        .alu_z (alu_z),
        .alu_f (alu_f),
        .addr  (addr),
        .data  (data),
        .we    (we),
        .out   (out),
        .pc    (pc)
    );

    cpu_alu u_alu (
        .op (alu_op),
        .y  (alu_y),
        .z  (alu_z),
        .f  (alu_f)
    );

endmodule

//--- sim/tb_mem_model.sv
module tb_mem_model (
    input  logic           clk,
    input  logic           we,
    input  cpu_pkg::addr_t addr,
    input  cpu_pkg::word_t wdata,
    output cpu_pkg::word_t rdata
);

    cpu_pkg::word_t ram [64];
    cpu_pkg::word_t rd_q = '0;

    // read data follows the address by one clock and keeps the old word on a write
    always @(posedge clk) begin
        rd_q <= ram[addr];
        if (we) begin
            ram[addr] = wdata;
        end
    end

    assign rdata = rd_q;

    // preload before the clock starts
    task automatic load_word(input cpu_pkg::addr_t a, input cpu_pkg::word_t v);
        ram[a] = v;
    endtask

    // read-back for the final memory compare
    function automatic cpu_pkg::word_t read_word(input cpu_pkg::addr_t a);
        return ram[a];
    endfunction

endmodule

//--- sim/tb_cpu.sv
module tb_cpu;

    localparam int NUM_OPS     = 30;
    localparam int PROG_BASE   = 8;
    localparam int STOP_ADDR   = PROG_BASE + NUM_OPS;
    localparam int PTR_BASE    = 40;
    localparam int HALT_CYCLES = 50;
    // forty cycles per program word plus reset and halt margin
    localparam int TIMEOUT     = 40 * (NUM_OPS + 1) + 200;
    localparam cpu_pkg::addr_t HALT_PC = 6'(STOP_ADDR + 1);

    logic           clk;
    logic           rst_n;
    logic           status;
    logic           we;
    cpu_pkg::word_t mem_rdata;
    cpu_pkg::word_t in_port;
    cpu_pkg::word_t data;
    cpu_pkg::word_t out_port;
    cpu_pkg::addr_t addr;
    cpu_pkg::addr_t pc;

    logic [31:0]    rng;
    cpu_pkg::word_t ref_mem [64];
    cpu_pkg::word_t in_vals [$];
    cpu_pkg::addr_t exp_waddr [$];
    cpu_pkg::word_t exp_wdata [$];
    cpu_pkg::word_t exp_out [$];
    cpu_pkg::word_t out_q;
    logic           status_q;
    int             write_seen;
    int             status_rises;
    int             cycles;
    int             reset_errs;
    int             write_errs;
    int             out_errs;
    int             halt_errs;
    int             mem_errs;

    cpu_top #(
        .PROG_START (cpu_pkg::addr_t'(PROG_BASE))
    ) DUT (
        .clk    (clk),
        .rst_n  (rst_n),
        .mem    (mem_rdata),
        .in     (in_port),
        .status (status),
        .we     (we),
        .addr   (addr),
        .data   (data),
        .out    (out_port),
        .pc     (pc)
    );

    tb_mem_model mem0 (
        .clk   (clk),
        .we    (we),
        .addr  (addr),
        .wdata (data),
        .rdata (mem_rdata)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic logic [31:0] rand_word();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic logic [3:0] pick_opcode(input logic [2:0] s);
        case (s)
            3'd0:    return cpu_pkg::OP_MOV;
            3'd1:    return cpu_pkg::OP_ADD;
            3'd2:    return cpu_pkg::OP_SUB;
            3'd3:    return cpu_pkg::OP_MUL;
            3'd4:    return cpu_pkg::OP_IN;
            3'd5:    return cpu_pkg::OP_OUT;
            3'd6:    return cpu_pkg::OP_ADD;
            default: return cpu_pkg::OP_MUL;
        endcase
    endfunction

    // written operands use data regs 0..3 or pointer regs 4..7
    function automatic logic [3:0] dest_field(input logic [3:0] b);
        return b[3] ? {2'b11, b[1:0]} : {2'b00, b[1:0]};
    endfunction

    function automatic logic [3:0] src_field(input logic [3:0] b);
        return b[3] ? {2'b11, b[1:0]} : {1'b0, b[2:0]};
    endfunction

    // address that an operand field reads and writes
    function automatic cpu_pkg::addr_t operand_addr(input logic [3:0] f);
        cpu_pkg::word_t p;
        p = ref_mem[{3'b000, f[2:0]}];
        return f[3] ? p[5:0] : {3'b000, f[2:0]};
    endfunction

    task automatic build_program();
        logic [31:0] r;
        logic [3:0]  opc;
        logic [3:0]  fx;
        for (int a = 0; a < 64; a++) begin
            ref_mem[a[5:0]] = {~a[5:0], 4'h5, a[5:0]};
        end
        // pointer registers always hold 40..47
        for (int a = 0; a < 4; a++) begin
            r = rand_word();
            ref_mem[a[5:0]] = r[15:0];
            r = rand_word();
            ref_mem[6'(a + 4)] = {10'd0, 3'b101, r[2:0]};
        end
        for (int a = 0; a < 8; a++) begin
            r = rand_word();
            ref_mem[6'(PTR_BASE + a)] = r[15:0];
        end
        for (int i = 0; i < NUM_OPS; i++) begin
            r   = rand_word();
            opc = pick_opcode(r[14:12]);
            fx  = (opc == cpu_pkg::OP_OUT) ? src_field(r[3:0]) : dest_field(r[3:0]);
            ref_mem[6'(PROG_BASE + i)] = {opc, fx, src_field(r[7:4]), src_field(r[11:8])};
        end
        ref_mem[6'(STOP_ADDR)] = {cpu_pkg::OP_STOP, 12'h000};
        for (int a = 0; a < 64; a++) begin
            mem0.load_word(a[5:0], ref_mem[a[5:0]]);
        end
    endtask

    task automatic store_result(input cpu_pkg::addr_t a, input cpu_pkg::word_t v);
        logic [31:0] r;
        exp_waddr.push_back(a);
        exp_wdata.push_back(v);
        ref_mem[a] = v;
        // in port moves on after every write
        r = rand_word();
        in_vals.push_back(r[15:0]);
    endtask

    task automatic run_model();
        logic [31:0]    r;
        logic [15:0]    ins;
        cpu_pkg::addr_t dest;
        cpu_pkg::word_t vx;
        cpu_pkg::word_t vy;
        cpu_pkg::word_t vz;
        cpu_pkg::word_t last_out;
        last_out = '0;
        r = rand_word();
        in_vals.push_back(r[15:0]);
        for (int i = 0; i < NUM_OPS; i++) begin
            ins  = ref_mem[6'(PROG_BASE + i)];
            dest = operand_addr(ins[11:8]);
            vx   = ref_mem[dest];
            vy   = ref_mem[operand_addr(ins[7:4])];
            vz   = ref_mem[operand_addr(ins[3:0])];
            case (ins[15:12])
                cpu_pkg::OP_MOV: store_result(dest, vy);
                cpu_pkg::OP_ADD: store_result(dest, vy + vz);
                cpu_pkg::OP_SUB: store_result(dest, vy - vz);
                cpu_pkg::OP_MUL: store_result(dest, vy * vz);
                cpu_pkg::OP_IN:  store_result(dest, in_vals[in_vals.size() - 1]);
                cpu_pkg::OP_OUT: begin
                    // a repeated value is no visible change
                    if (vx != last_out) begin
                        exp_out.push_back(vx);
                        last_out = vx;
                    end
                end
                default: begin
                end
            endcase
        end
    endtask

    task automatic check_word(input cpu_pkg::addr_t a);
        cpu_pkg::word_t got;
        got = mem0.read_word(a);
        mem_check: assert (got == ref_mem[a]) else begin
            mem_errs++;
            $display("error at %0t: mem[%0d] is %h, expected %h", $time, a, got, ref_mem[a]);
        end
    endtask

    function automatic int total_errors();
        return reset_errs + write_errs + out_errs + halt_errs + mem_errs;
    endfunction

    task automatic report_counts();
        $display("errors: reset %0d, write %0d, out %0d, halt %0d, memory %0d",
                 reset_errs, write_errs, out_errs, halt_errs, mem_errs);
    endtask

    always @(posedge clk) begin
        #1;
        in_port = in_vals[write_seen];
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("timeout: the CPU did not halt within %0d cycles", TIMEOUT);
            report_counts();
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (we) begin
                write_seen++;
                if (exp_waddr.size() == 0) begin
                    write_errs++;
                    $display("extra write to address %0d at time %0t", addr, $time);
                end else begin
                    write_check: assert (addr == exp_waddr[0] && data == exp_wdata[0]) else begin
                        write_errs++;
                        $display("error at %0t: write of %h to %0d, expected %h to %0d",
                                 $time, data, addr, exp_wdata[0], exp_waddr[0]);
                    end
                    void'(exp_waddr.pop_front());
                    void'(exp_wdata.pop_front());
                end
            end
            if (out_port != out_q) begin
                if (exp_out.size() == 0) begin
                    out_errs++;
                    $display("out changed to %h at time %0t with no OUT left", out_port, $time);
                end else begin
                    out_check: assert (out_port == exp_out[0]) else begin
                        out_errs++;
                        $display("error at %0t: out is %h, expected %h",
                                 $time, out_port, exp_out[0]);
                    end
                    void'(exp_out.pop_front());
                end
            end
            if (status && !status_q) begin
                status_rises++;
            end
            if (status) begin
                halt_check: assert (!we && pc == HALT_PC) else begin
                    halt_errs++;
                    $display("error at %0t: after halt we %b pc %0d, expected we 0 pc %0d",
                             $time, we, pc, HALT_PC);
                end
            end
            status_q = status;
            out_q    = out_port;
        end
    end

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        out_q    = '0;
        status_q = 1'b0;
        rng      = 32'hcc7802d3;
        build_program();
        run_model();
        in_port = in_vals[0];
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        #1;
        reset_check: assert (!we && !status && out_port == '0 && data == '0) else begin
            reset_errs++;
            $display("error at %0t: after reset we %b status %b out %h data %h",
                     $time, we, status, out_port, data);
        end
        while (!status) begin
            @(negedge clk);
        end
        repeat (HALT_CYCLES) @(negedge clk);
        #1;
        for (int a = 0; a < 8; a++) begin
            check_word(a[5:0]);
            check_word(6'(PTR_BASE + a));
        end
        if (exp_waddr.size() != 0) begin
            write_errs++;
            $display("%0d predicted writes never happened", exp_waddr.size());
        end
        if (exp_out.size() != 0) begin
            out_errs++;
            $display("%0d predicted out values never appeared", exp_out.size());
        end
        if (status_rises != 1) begin
            halt_errs++;
            $display("status rose %0d times instead of once", status_rises);
        end
        report_counts();
        if (total_errors() == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- filelist.f
rtl/cpu_pkg.sv
rtl/cpu_ctrl_if.sv
rtl/cpu_step_counter.sv
rtl/cpu_sequencer.sv
rtl/cpu_alu.sv
rtl/cpu_datapath.sv
rtl/cpu_top.sv
sim/tb_mem_model.sv
sim/tb_cpu.sv

//--- Makefile
.PHONY: all run clean

all: run

obj_dir/Vtb_cpu: filelist.f $(wildcard rtl/*.sv) $(wildcard sim/*.sv)
	verilator --binary --timing --assert --top-module tb_cpu -f filelist.f -o Vtb_cpu

sim.log: obj_dir/Vtb_cpu
	./obj_dir/Vtb_cpu > sim.log; cat sim.log

run: sim.log
	grep -q '^\*\*\* TEST PASSED \*\*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log
